/* src.f */
miss_pkg.sv
miss_req_unit.sv
mshr_table.sv
refill_resp_fifo.sv
refill_beat_counter.sv
refill_fsm.sv
miss_handler.sv
tb_miss_handler.sv

/* tb_miss_handler.sv */
`timescale 1ns/1ps
/*
 * Testbench of the miss handler with a memory model and a refill-port model
 * Memory returns pending lines in random order and every 8th line is an error line
 */
module tb_miss_handler;

    localparam int N_MISS  = 40;
    localparam int TIMEOUT = N_MISS * 80 * 10;

    typedef struct packed {
        logic [miss_pkg::MSHR_W-1:0]  id;
        logic [miss_pkg::NLINE_W-1:0] nline;
        logic                         err;
    } line_t;

    logic                         clk_i = 1'b0;
    logic                         rst_ni;
    logic                         alloc_valid_i, alloc_ready_o, mshr_full_o;
    miss_pkg::miss_alloc_t        alloc_i;
    logic                         mem_req_valid_o, mem_req_ready_i;
    miss_pkg::mem_req_t           mem_req_o;
    logic                         mem_resp_valid_i, mem_resp_ready_o;
    miss_pkg::mem_resp_t          mem_resp_i;
    logic                         refill_req_o, refill_gnt_i;
    logic                         refill_wr_valid_o, dir_wr_valid_o, core_rsp_valid_o;
    miss_pkg::refill_wr_t         refill_wr_o;
    miss_pkg::dir_entry_t         dir_wr_o;
    miss_pkg::core_rsp_t          core_rsp_o;
    logic [miss_pkg::NLINE_W-1:0] check_nline_i;
    logic                         check_hit_o, mshr_empty_o;

    integer seed = 52576;
    // Table contents as the DUT should hold them
    logic [miss_pkg::MSHR_N-1:0] exp_valid;
    miss_pkg::miss_alloc_t       exp_req [miss_pkg::MSHR_N];
    miss_pkg::mem_req_t          exp_mem_q [$];
    line_t                       mem_pend_q [$];
    line_t                       done_q [$];
    miss_pkg::core_rsp_t         exp_rsp_q [$];
    miss_pkg::refill_wr_t        exp_wr;
    miss_pkg::dir_entry_t        exp_dir;
    miss_pkg::core_rsp_t         exp_rsp;
    line_t                       cur, tx_line;
    logic                        in_refill, sending, req_fire, resp_fire, popping;
    int                          wr_cnt, alloc_cnt, req_cnt, dir_cnt, slot, pick, beat_no;
    // Beats held in the response buffer
    int                          fifo_beats;

    always #5 clk_i = ~clk_i;

    miss_handler dut0 (.*);

    // Expected content of one beat of a line
    function automatic logic [miss_pkg::DATA_W-1:0] ref_beat(
        input logic [miss_pkg::NLINE_W-1:0] nline,
        input logic [miss_pkg::BEAT_W-1:0]  beat
    );
        logic [31:0] mix;
        mix = 32'(nline) * 32'h9E37_79B1 + 32'(beat);
        return {nline ^ 26'h2A5_A5A5, beat, 4'hC, mix};
    endfunction

    function automatic int lowest_free(input logic [miss_pkg::MSHR_N-1:0] v);
        for (int i = 0; i < miss_pkg::MSHR_N; i++) begin
            if (!v[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic line_pending(input logic [miss_pkg::NLINE_W-1:0] nline);
        for (int i = 0; i < miss_pkg::MSHR_N; i++) begin
            if (exp_valid[i] && exp_req[i].nline == nline) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h exp %h", name, got, exp));
        end
    endtask

    task automatic check_mem_req(input miss_pkg::mem_req_t got, input miss_pkg::mem_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL mem_req_o got %h exp %h", got, exp));
        end
    endtask

    task automatic check_refill_wr(input miss_pkg::refill_wr_t got,
                                   input miss_pkg::refill_wr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL refill_wr_o got %h exp %h", got, exp));
        end
    endtask

    task automatic check_dir(input miss_pkg::dir_entry_t got, input miss_pkg::dir_entry_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL dir_wr_o got %h exp %h", got, exp));
        end
    endtask

    task automatic check_core_rsp(input miss_pkg::core_rsp_t got, input miss_pkg::core_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL core_rsp_o got %h exp %h", got, exp));
        end
    endtask

    // Monitor at the falling edge, where all DUT outputs are settled
    always @(negedge clk_i) begin
        if (rst_ni) begin
            req_fire  = mem_req_valid_o && mem_req_ready_i;
            resp_fire = mem_resp_valid_i && mem_resp_ready_o;
            popping   = in_refill;
            check_flag("check_hit_o", check_hit_o, line_pending(check_nline_i));
            check_flag("mshr_full_o", mshr_full_o, &exp_valid);
            check_flag("mshr_empty_o", mshr_empty_o, ~|exp_valid && !in_refill);
            check_flag("alloc_ready_o", alloc_ready_o, exp_mem_q.size() == 0);
            check_flag("mem_req_valid_o", mem_req_valid_o, exp_mem_q.size() != 0);
            check_flag("refill_req_o", refill_req_o, !in_refill && done_q.size() != 0);
            // A last beat also needs a free line record
            check_flag("mem_resp_ready_o", mem_resp_ready_o,
                       fifo_beats < miss_pkg::DATA_DEPTH
                       && !(mem_resp_i.last
                            && done_q.size() + in_refill == miss_pkg::META_DEPTH));
            if (alloc_valid_i && alloc_ready_o) begin
                slot = lowest_free(exp_valid);
                if (slot < 0) begin
                    abort_run("allocation accepted while every table entry is pending");
                end
                exp_valid[slot] = 1'b1;
                exp_req[slot]   = alloc_i;
                exp_mem_q.push_back('{nline: alloc_i.nline, id: slot[miss_pkg::MSHR_W-1:0]});
            end
            if (req_fire) begin
                check_mem_req(mem_req_o, exp_mem_q.pop_front());
                mem_pend_q.push_back('{id: mem_req_o.id, nline: mem_req_o.nline,
                                       err: (req_cnt % 8) == 7});
                req_cnt++;
            end
            if (resp_fire && mem_resp_i.last) begin
                done_q.push_back('{id: mem_resp_i.id, nline: exp_req[mem_resp_i.id].nline,
                                   err: mem_resp_i.error});
            end
            if (refill_wr_valid_o) begin
                if (!in_refill || cur.err) begin
                    abort_run("data write outside the refill of a good line");
                end
                exp_wr = '{set: cur.nline[miss_pkg::SET_W-1:0], way: exp_req[cur.id].way,
                           beat: wr_cnt[miss_pkg::BEAT_W-1:0],
                           data: ref_beat(cur.nline, wr_cnt[miss_pkg::BEAT_W-1:0])};
                check_refill_wr(refill_wr_o, exp_wr);
                wr_cnt++;
            end
            if (dir_wr_valid_o) begin
                if (!in_refill || wr_cnt != (cur.err ? 0 : miss_pkg::BEATS)) begin
                    abort_run("directory write with a wrong number of data writes");
                end
                exp_dir = '{set: cur.nline[miss_pkg::SET_W-1:0], way: exp_req[cur.id].way,
                            valid: !cur.err,
                            tag: cur.nline[miss_pkg::NLINE_W-1 -: miss_pkg::TAG_W]};
                check_dir(dir_wr_o, exp_dir);
                exp_valid[cur.id] = 1'b0;
                in_refill = 1'b0;
                dir_cnt++;
            end
            if (core_rsp_valid_o) begin
                if (exp_rsp_q.size() == 0) begin
                    abort_run("core response for a miss that did not ask for one");
                end
                check_core_rsp(core_rsp_o, exp_rsp_q.pop_front());
            end
            // Grant starts the refill of the oldest returned line
            if (refill_req_o && refill_gnt_i) begin
                if (in_refill || done_q.size() == 0) begin
                    abort_run("refill requested with no completed line waiting");
                end
                cur       = done_q.pop_front();
                in_refill = 1'b1;
                wr_cnt    = 0;
                if (exp_req[cur.id].need_rsp) begin
                    exp_rsp = '{data: ref_beat(cur.nline, exp_req[cur.id].word),
                                sid: exp_req[cur.id].sid, tid: exp_req[cur.id].tid,
                                error: cur.err};
                    exp_rsp_q.push_back(exp_rsp);
                end
            end
            // One beat enters per transfer and one leaves per refill cycle
            if (resp_fire) begin
                fifo_beats++;
            end
            if (popping) begin
                fifo_beats--;
            end
        end
    end

    // Stimulus, 1 ns after each rising edge
    initial begin
        rst_ni           = 1'b0;
        alloc_valid_i    = 1'b0;
        alloc_i          = '0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        refill_gnt_i     = 1'b0;
        check_nline_i    = '0;
        exp_valid        = '0;
        in_refill        = 1'b0;
        sending          = 1'b0;
        req_fire         = 1'b0;
        resp_fire        = 1'b0;
        popping          = 1'b0;
        wr_cnt           = 0;
        alloc_cnt        = 0;
        req_cnt          = 0;
        dir_cnt          = 0;
        beat_no          = 0;
        fifo_beats       = 0;
        repeat (2) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        forever begin
            @(posedge clk_i);
            #1;
            mem_req_ready_i = ($random(seed) % 4) != 0;
            refill_gnt_i    = ($random(seed) % 2) != 0;
            alloc_valid_i   = 1'b0;
            if (alloc_cnt < N_MISS && alloc_ready_o && !mshr_full_o
                && ($random(seed) % 2) != 0) begin
                alloc_i.nline    = miss_pkg::NLINE_W'($random(seed));
                alloc_i.way      = miss_pkg::WAY_W'($random(seed));
                alloc_i.word     = miss_pkg::BEAT_W'($random(seed));
                alloc_i.sid      = miss_pkg::ID_W'($random(seed));
                alloc_i.tid      = miss_pkg::ID_W'($random(seed));
                alloc_i.need_rsp = ($random(seed) % 4) != 0;
                alloc_valid_i    = 1'b1;
                alloc_cnt++;
            end
            // Half the lookups target a line that may be pending
            check_nline_i = miss_pkg::NLINE_W'($random(seed));
            pick = $unsigned($random(seed)) % miss_pkg::MSHR_N;
            if (exp_valid[pick] && ($random(seed) % 2) != 0) begin
                check_nline_i = exp_req[pick].nline;
            end
            if (resp_fire) begin
                beat_no++;
                if (beat_no == miss_pkg::BEATS) begin
                    sending = 1'b0;
                end
            end
            if (!sending && mem_pend_q.size() > 0 && ($random(seed) % 2) != 0) begin
                pick    = $unsigned($random(seed)) % mem_pend_q.size();
                tx_line = mem_pend_q[pick];
                mem_pend_q.delete(pick);
                sending = 1'b1;
                beat_no = 0;
            end
            mem_resp_valid_i = sending;
            mem_resp_i = '{data: ref_beat(tx_line.nline, beat_no[miss_pkg::BEAT_W-1:0]),
                           id: tx_line.id, error: tx_line.err,
                           last: beat_no == miss_pkg::BEATS - 1};
        end
    end

    initial begin
        wait (dir_cnt == N_MISS);
        repeat (4) @(posedge clk_i);
        #1;
        if (exp_rsp_q.size() != 0 || !mshr_empty_o) begin
            abort_run("core responses missing or table not empty after all refills");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    initial begin
        #(TIMEOUT);
        abort_run("the run hung because not all misses refilled within the time limit");
    end

endmodule

/* miss_handler.sv */
`timescale 1ns/1ps
/*
 * Cache miss handler top level
 * Allocate only while alloc_ready_o is high and mshr_full_o is low
 */
module miss_handler (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         alloc_valid_i,
    input  miss_pkg::miss_alloc_t        alloc_i,
    output logic                         alloc_ready_o,
    output logic                         mshr_full_o,
    output logic                         mem_req_valid_o,
    output miss_pkg::mem_req_t           mem_req_o,
    input  logic                         mem_req_ready_i,
    input  logic                         mem_resp_valid_i,
    input  miss_pkg::mem_resp_t          mem_resp_i,
    output logic                         mem_resp_ready_o,
    output logic                         refill_req_o,
    input  logic                         refill_gnt_i,
    output logic                         refill_wr_valid_o,
    output miss_pkg::refill_wr_t         refill_wr_o,
    output logic                         dir_wr_valid_o,
    output miss_pkg::dir_entry_t         dir_wr_o,
    output logic                         core_rsp_valid_o,
    output miss_pkg::core_rsp_t          core_rsp_o,
    input  logic [miss_pkg::NLINE_W-1:0] check_nline_i,
    output logic                         check_hit_o,
    output logic                         mshr_empty_o
);

    logic [miss_pkg::MSHR_W-1:0] free_idx;
    logic                        tbl_empty;
    logic                        meta_avail, meta_pop, beat_pop;
    miss_pkg::refill_meta_t      meta;
    logic [miss_pkg::DATA_W-1:0] beat;
    logic                        ack;
    miss_pkg::mshr_entry_t       ack_entry;
    logic                        cnt_start, cnt_step, cnt_last, word_hit;
    logic [miss_pkg::BEAT_W-1:0] beat_idx;
    logic                        busy;

    miss_req_unit u_req (
        .clk_i, .rst_ni,
        .alloc_valid_i   (alloc_valid_i),
        .alloc_nline_i   (alloc_i.nline),
        .alloc_ready_o   (alloc_ready_o),
        .free_idx_i      (free_idx),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o)
    );

    mshr_table u_mshr (
        .clk_i, .rst_ni,
        .alloc_i       (alloc_valid_i && alloc_ready_o),
        .alloc_data_i  (alloc_i),
        .free_idx_o    (free_idx),
        .full_o        (mshr_full_o),
        .empty_o       (tbl_empty),
        .check_nline_i (check_nline_i),
        .check_hit_o   (check_hit_o),
        .ack_i         (ack),
        .ack_idx_i     (meta.id),
        .ack_entry_o   (ack_entry)
    );

    refill_resp_fifo u_fifo (
        .clk_i, .rst_ni,
        .resp_valid_i (mem_resp_valid_i),
        .resp_i       (mem_resp_i),
        .resp_ready_o (mem_resp_ready_o),
        .meta_avail_o (meta_avail),
        .meta_o       (meta),
        .meta_pop_i   (meta_pop),
        .beat_o       (beat),
        .beat_pop_i   (beat_pop)
    );

    refill_beat_counter u_cnt (
        .clk_i, .rst_ni,
        .start_i    (cnt_start),
        .step_i     (cnt_step),
        .req_word_i (ack_entry.req.word),
        .beat_o     (beat_idx),
        .last_o     (cnt_last),
        .word_hit_o (word_hit)
    );

    refill_fsm u_fsm (
        .clk_i, .rst_ni,
        .meta_avail_i      (meta_avail),
        .meta_i            (meta),
        .meta_pop_o        (meta_pop),
        .beat_i            (beat),
        .beat_pop_o        (beat_pop),
        .refill_req_o      (refill_req_o),
        .refill_gnt_i      (refill_gnt_i),
        .ack_o             (ack),
        .entry_i           (ack_entry),
        .cnt_start_o       (cnt_start),
        .cnt_step_o        (cnt_step),
        .beat_idx_i        (beat_idx),
        .last_i            (cnt_last),
        .word_hit_i        (word_hit),
        .refill_wr_valid_o (refill_wr_valid_o),
        .refill_wr_o       (refill_wr_o),
        .dir_wr_valid_o    (dir_wr_valid_o),
        .dir_wr_o          (dir_wr_o),
        .core_rsp_valid_o  (core_rsp_valid_o),
        .core_rsp_o        (core_rsp_o),
        .busy_o            (busy)
    );

    // Empty only once the last refill has left the write state
    assign mshr_empty_o = tbl_empty && !busy;

endmodule

/* refill_fsm.sv */
`timescale 1ns/1ps
/*
 * Refill sequencer, one beat per cycle after the grant
 * The directory is written on the last beat and the core is always ready
 */
module refill_fsm (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        meta_avail_i,
    input  miss_pkg::refill_meta_t      meta_i,
    output logic                        meta_pop_o,
    input  logic [miss_pkg::DATA_W-1:0] beat_i,
    output logic                        beat_pop_o,
    output logic                        refill_req_o,
    input  logic                        refill_gnt_i,
    output logic                        ack_o,
    input  miss_pkg::mshr_entry_t       entry_i,
    output logic                        cnt_start_o,
    output logic                        cnt_step_o,
    input  logic [miss_pkg::BEAT_W-1:0] beat_idx_i,
    input  logic                        last_i,
    input  logic                        word_hit_i,
    output logic                        refill_wr_valid_o,
    output miss_pkg::refill_wr_t        refill_wr_o,
    output logic                        dir_wr_valid_o,
    output miss_pkg::dir_entry_t        dir_wr_o,
    output logic                        core_rsp_valid_o,
    output miss_pkg::core_rsp_t         core_rsp_o,
    output logic                        busy_o
);

    typedef enum logic {
        IDLE,
        WRITE
    } state_e;

    state_e state_q, state_d;
    logic   go;

    assign refill_req_o = (state_q == IDLE) && meta_avail_i;
    assign go           = refill_req_o && refill_gnt_i;
    assign busy_o       = (state_q == WRITE);

    assign cnt_start_o = go;
    assign cnt_step_o  = busy_o;
    assign beat_pop_o  = busy_o;
    // Line done on its last beat
    assign meta_pop_o  = busy_o && last_i;
    assign ack_o       = meta_pop_o;

    always_comb begin
        state_d = state_q;
        if (go) begin
            state_d = WRITE;
        end else if (meta_pop_o) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Error lines still drain their beats but write no data
    assign refill_wr_valid_o = busy_o && !meta_i.error;
    assign refill_wr_o.set   = entry_i.req.nline[miss_pkg::SET_W-1:0];
    assign refill_wr_o.way   = entry_i.req.way;
    assign refill_wr_o.beat  = beat_idx_i;
    assign refill_wr_o.data  = beat_i;

    assign dir_wr_valid_o = meta_pop_o;
    assign dir_wr_o.set   = entry_i.req.nline[miss_pkg::SET_W-1:0];
    assign dir_wr_o.way   = entry_i.req.way;
    assign dir_wr_o.valid = !meta_i.error;
    assign dir_wr_o.tag   = entry_i.req.nline[miss_pkg::NLINE_W-1 -: miss_pkg::TAG_W];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            core_rsp_valid_o <= 1'b0;
        end else begin
            core_rsp_valid_o <= busy_o && word_hit_i && entry_i.req.need_rsp;
        end
    end

    // Requested word captured one cycle before the response
    always_ff @(posedge clk_i) begin
        if (busy_o && word_hit_i) begin
            core_rsp_o.data  <= beat_i;
            core_rsp_o.sid   <= entry_i.req.sid;
            core_rsp_o.tid   <= entry_i.req.tid;
            core_rsp_o.error <= meta_i.error;
        end
    end

    // Data writes only while a pending miss is being refilled
    wr_in_write_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_wr_valid_o |-> entry_i.valid);

endmodule

/* refill_beat_counter.sv */
`timescale 1ns/1ps
/*
 * Beat counter of the refill in progress
 * start_i has priority over step_i
 */
module refill_beat_counter (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        start_i,
    input  logic                        step_i,
    input  logic [miss_pkg::BEAT_W-1:0] req_word_i,
    output logic [miss_pkg::BEAT_W-1:0] beat_o,
    output logic                        last_o,
    output logic                        word_hit_o
);

    logic [miss_pkg::BEAT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= '0;
        end else if (step_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign beat_o     = cnt_q;
    assign last_o     = (cnt_q == miss_pkg::BEAT_W'(miss_pkg::BEATS - 1));
    // Beat that carries the word the core asked for
    assign word_hit_o = (cnt_q == req_word_i);

endmodule

/* refill_resp_fifo.sv */
`timescale 1ns/1ps
/*
 * Buffers memory response beats and one record per completed line
 * Every line, error lines included, must arrive as BEATS contiguous beats
 */
module refill_resp_fifo (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        resp_valid_i,
    input  miss_pkg::mem_resp_t         resp_i,
    output logic                        resp_ready_o,
    output logic                        meta_avail_o,
    output miss_pkg::refill_meta_t      meta_o,
    input  logic                        meta_pop_i,
    output logic [miss_pkg::DATA_W-1:0] beat_o,
    input  logic                        beat_pop_i
);

    // Pointers carry one wrap bit above the address
    logic [miss_pkg::DATA_AW:0] bwr_q, brd_q;
    logic [miss_pkg::META_AW:0] mwr_q, mrd_q;
    logic [miss_pkg::DATA_W-1:0] beat_mem [miss_pkg::DATA_DEPTH];
    miss_pkg::refill_meta_t      meta_mem [miss_pkg::META_DEPTH];
    logic beat_full, beat_empty, meta_full;
    logic beat_push, meta_push;

    assign beat_full  = (bwr_q ^ brd_q) == {1'b1, {miss_pkg::DATA_AW{1'b0}}};
    assign beat_empty = (bwr_q == brd_q);
    assign meta_full  = (mwr_q ^ mrd_q) == {1'b1, {miss_pkg::META_AW{1'b0}}};

    // A last beat also needs room for its line record
    assign resp_ready_o = !beat_full && !(resp_i.last && meta_full);
    assign beat_push    = resp_valid_i && resp_ready_o;
    assign meta_push    = beat_push && resp_i.last;

    assign meta_avail_o = (mwr_q != mrd_q);
    assign meta_o       = meta_mem[mrd_q[miss_pkg::META_AW-1:0]];
    assign beat_o       = beat_mem[brd_q[miss_pkg::DATA_AW-1:0]];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bwr_q <= '0;
            brd_q <= '0;
            mwr_q <= '0;
            mrd_q <= '0;
        end else begin
            if (beat_push) begin
                bwr_q <= bwr_q + 1'b1;
            end
            if (beat_pop_i) begin
                brd_q <= brd_q + 1'b1;
            end
            if (meta_push) begin
                mwr_q <= mwr_q + 1'b1;
            end
            if (meta_pop_i) begin
                mrd_q <= mrd_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_push) begin
            beat_mem[bwr_q[miss_pkg::DATA_AW-1:0]] <= resp_i.data;
        end
        if (meta_push) begin
            meta_mem[mwr_q[miss_pkg::META_AW-1:0]] <= '{id: resp_i.id, error: resp_i.error};
        end
    end

    no_pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (beat_pop_i |-> !beat_empty) and (meta_pop_i |-> meta_avail_o));

endmodule

/* mshr_table.sv */
`timescale 1ns/1ps
/*
 * Miss status holding table with MSHR_N entries
 * The caller must not allocate while full_o is high
 */
module mshr_table (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         alloc_i,
    input  miss_pkg::miss_alloc_t        alloc_data_i,
    output logic [miss_pkg::MSHR_W-1:0]  free_idx_o,
    output logic                         full_o,
    output logic                         empty_o,
    input  logic [miss_pkg::NLINE_W-1:0] check_nline_i,
    output logic                         check_hit_o,
    input  logic                         ack_i,
    input  logic [miss_pkg::MSHR_W-1:0]  ack_idx_i,
    output miss_pkg::mshr_entry_t        ack_entry_o
);

    logic [miss_pkg::MSHR_N-1:0] valid_q;
    miss_pkg::miss_alloc_t       req_q [miss_pkg::MSHR_N];

    // Scan downwards so the lowest free entry is the one kept
    always_comb begin
        free_idx_o = '0;
        for (int i = miss_pkg::MSHR_N - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx_o = miss_pkg::MSHR_W'(i);
            end
        end
    end

    always_comb begin
        check_hit_o = 1'b0;
        for (int i = 0; i < miss_pkg::MSHR_N; i++) begin
            if (valid_q[i] && (req_q[i].nline == check_nline_i)) begin
                check_hit_o = 1'b1;
            end
        end
    end

    assign full_o  = &valid_q;
    assign empty_o = ~|valid_q;

    // Read port for the refill in progress
    assign ack_entry_o.valid = valid_q[ack_idx_i];
    assign ack_entry_o.req   = req_q[ack_idx_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (ack_i) begin
                valid_q[ack_idx_i] <= 1'b0;
            end
            if (alloc_i) begin
                valid_q[free_idx_o] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            req_q[free_idx_o] <= alloc_data_i;
        end
    end

    alloc_not_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_i |-> !full_o);

    // A refill only ever completes a miss that is still pending
    ack_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> valid_q[ack_idx_i]);

endmodule

/* miss_req_unit.sv */
`timescale 1ns/1ps
/*
 * Issues one line read per accepted miss
 * Only one read waits for memory at a time, so no new miss is taken meanwhile
 */
module miss_req_unit (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         alloc_valid_i,
    input  logic [miss_pkg::NLINE_W-1:0] alloc_nline_i,
    output logic                         alloc_ready_o,
    input  logic [miss_pkg::MSHR_W-1:0]  free_idx_i,
    input  logic                         mem_req_ready_i,
    output logic                         mem_req_valid_o,
    output miss_pkg::mem_req_t           mem_req_o
);

    typedef enum logic {
        REQ_IDLE,
        REQ_SEND
    } req_state_e;

    req_state_e                   state_q, state_d;
    logic [miss_pkg::NLINE_W-1:0] nline_q;
    logic [miss_pkg::MSHR_W-1:0]  id_q;
    logic                         take;

    assign alloc_ready_o   = (state_q == REQ_IDLE);
    assign mem_req_valid_o = (state_q == REQ_SEND);
    assign take            = alloc_valid_i && alloc_ready_o;

    always_comb begin
        state_d = state_q;
        if (take) begin
            state_d = REQ_SEND;
        end else if (mem_req_valid_o && mem_req_ready_i) begin
            state_d = REQ_IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= REQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // The free index becomes the memory ID of this miss
    always_ff @(posedge clk_i) begin
        if (take) begin
            nline_q <= alloc_nline_i;
            id_q    <= free_idx_i;
        end
    end

    assign mem_req_o.nline = nline_q;
    assign mem_req_o.id    = id_q;

    mem_req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

/* miss_pkg.sv */
/*
 * Shared sizes and records of the miss handler
 * Memory beat, access and core words are all DATA_W bits and a line is BEATS beats
 * FIFO depths must be powers of two
 */
package miss_pkg;

    localparam int NLINE_W    = 26;
    localparam int SET_W      = 6;
    localparam int TAG_W      = 20;
    localparam int WAY_W      = 2;
    localparam int BEATS      = 4;
    localparam int BEAT_W     = 2;
    localparam int DATA_W     = 64;
    localparam int ID_W       = 4;
    localparam int MSHR_N     = 4;
    localparam int MSHR_W     = 2;
    localparam int DATA_DEPTH = 8;
    localparam int META_DEPTH = 2;
    // Buffer address widths
    localparam int DATA_AW    = $clog2(DATA_DEPTH);
    localparam int META_AW    = $clog2(META_DEPTH);

    typedef struct packed {
        logic [NLINE_W-1:0] nline;
        logic [WAY_W-1:0]   way;
        logic [BEAT_W-1:0]  word;
        logic [ID_W-1:0]    sid;
        logic [ID_W-1:0]    tid;
        logic               need_rsp;
    } miss_alloc_t;

    typedef struct packed {
        logic        valid;
        miss_alloc_t req;
    } mshr_entry_t;

    // Memory transaction ID is the MSHR index
    typedef struct packed {
        logic [NLINE_W-1:0] nline;
        logic [MSHR_W-1:0]  id;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [MSHR_W-1:0] id;
        logic              error;
        logic              last;
    } mem_resp_t;

    typedef struct packed {
        logic [MSHR_W-1:0] id;
        logic              error;
    } refill_meta_t;

    typedef struct packed {
        logic [SET_W-1:0]  set;
        logic [WAY_W-1:0]  way;
        logic [BEAT_W-1:0] beat;
        logic [DATA_W-1:0] data;
    } refill_wr_t;

    typedef struct packed {
        logic [SET_W-1:0] set;
        logic [WAY_W-1:0] way;
        logic             valid;
        logic [TAG_W-1:0] tag;
    } dir_entry_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   sid;
        logic [ID_W-1:0]   tid;
        logic              error;
    } core_rsp_t;

endpackage
